/* hw/xbar_defines.svh */
`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// Bus widths
`define XBAR_ADDR_W        32
`define XBAR_DATA_W        32
`define XBAR_ID_W          4

// Slice layout
`define XBAR_N_SLICES      4
`define XBAR_SLICE_SEL_W   2
`define XBAR_SLICE_WORDS   16
`define XBAR_WORD_SEL_W    4

// Queue depths and credits
`define XBAR_SLICE_DEPTH   2
`define XBAR_IN_DEPTH      4
`define XBAR_RSP_CREDITS   2

// Address bits 31..14 of the window 0x1000_0000 to 0x1000_3FFF
`define XBAR_MAP_BASE      18'h04000

`endif

/* hw/xbar_pkg.sv */
package xbar_pkg;

  // Request opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Response status
  typedef enum logic {
    RSP_OKAY   = 1'b0,
    RSP_DECERR = 1'b1
  } rsp_status_e;

endpackage

/* hw/req_decoder.sv */
`include "xbar_defines.svh"

module req_decoder (
  input  logic                                clk_i,
  input  logic                                ndmreset_n,
  input  logic                                req_valid_i,
  input  xbar_pkg::op_e                       req_op_i,
  input  logic [`XBAR_ID_W-1:0]               req_id_i,
  input  logic [`XBAR_ADDR_W-1:0]             req_addr_i,
  input  logic [`XBAR_DATA_W-1:0]             req_wdata_i,
  output logic                                req_credit_o,
  output logic [`XBAR_N_SLICES-1:0]           slc_valid_o,
  output xbar_pkg::op_e                       slc_op_o,
  output logic [`XBAR_ID_W-1:0]               slc_id_o,
  output logic [`XBAR_WORD_SEL_W-1:0]         slc_word_o,
  output logic [`XBAR_DATA_W-1:0]             slc_wdata_o,
  input  logic [`XBAR_N_SLICES-1:0]           slc_credit_i,
  output logic                                err_valid_o,
  output logic [`XBAR_ID_W-1:0]               err_id_o,
  input  logic                                err_ack_i
);
  import xbar_pkg::*;

  localparam int PtrW = $clog2(`XBAR_IN_DEPTH);
  localparam int CntW = $clog2(`XBAR_IN_DEPTH + 1);
  localparam int CrdW = $clog2(`XBAR_SLICE_DEPTH + 1);

  op_e                                 q_op    [`XBAR_IN_DEPTH];
  logic [`XBAR_ID_W-1:0]               q_id    [`XBAR_IN_DEPTH];
  logic [`XBAR_ADDR_W-1:0]             q_addr  [`XBAR_IN_DEPTH];
  logic [`XBAR_DATA_W-1:0]             q_wdata [`XBAR_IN_DEPTH];
  logic [PtrW-1:0]                     wr_ptr_q;
  logic [PtrW-1:0]                     rd_ptr_q;
  logic [CntW-1:0]                     count_q;
  logic [`XBAR_N_SLICES-1:0][CrdW-1:0] crd_q;

  logic [`XBAR_ADDR_W-1:0]             head_addr;
  logic                                head_mapped;
  logic [`XBAR_SLICE_SEL_W-1:0]        head_slice;
  logic                                pop;

  // --------------------------------------------------------------------------
  // Address decode of the queue head
  // --------------------------------------------------------------------------
  assign head_addr   = q_addr[rd_ptr_q];
  assign head_mapped = (head_addr[31:14] == `XBAR_MAP_BASE) &&
                       (head_addr[11:6] == '0) && (head_addr[1:0] == '0);
  assign head_slice  = head_addr[13:12];

  // Head waits for a slice credit or a free error slot
  assign pop = (count_q != '0) &&
               (head_mapped ? (crd_q[head_slice] != '0) : (!err_valid_o || err_ack_i));

  always_comb begin
    slc_valid_o = '0;
    if (pop && head_mapped) begin
      slc_valid_o[head_slice] = 1'b1;
    end
  end

  assign slc_op_o    = q_op[rd_ptr_q];
  assign slc_id_o    = q_id[rd_ptr_q];
  assign slc_word_o  = head_addr[5:2];
  assign slc_wdata_o = q_wdata[rd_ptr_q];

  // --------------------------------------------------------------------------
  // Ingress queue, credits and error slot
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      q_op[wr_ptr_q]    <= req_op_i;
      q_id[wr_ptr_q]    <= req_id_i;
      q_addr[wr_ptr_q]  <= req_addr_i;
      q_wdata[wr_ptr_q] <= req_wdata_i;
    end
    if (pop && !head_mapped) begin
      err_id_o <= q_id[rd_ptr_q];
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      req_credit_o <= 1'b0;
      err_valid_o  <= 1'b0;
      for (int i = 0; i < `XBAR_N_SLICES; i++) begin
        crd_q[i] <= CrdW'(`XBAR_SLICE_DEPTH);
      end
    end else begin
      req_credit_o <= pop;
      if (req_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(`XBAR_IN_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(`XBAR_IN_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (req_valid_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!req_valid_i && pop) begin
        count_q <= count_q - 1'b1;
      end
      for (int i = 0; i < `XBAR_N_SLICES; i++) begin
        if (slc_valid_o[i] && !slc_credit_i[i]) begin
          crd_q[i] <= crd_q[i] - 1'b1;
        end else if (!slc_valid_o[i] && slc_credit_i[i]) begin
          crd_q[i] <= crd_q[i] + 1'b1;
        end
      end
      if (pop && !head_mapped) begin
        err_valid_o <= 1'b1;
      end else if (err_ack_i) begin
        err_valid_o <= 1'b0;
      end
    end
  end

endmodule

/* hw/mem_slice.sv */
`include "xbar_defines.svh"

module mem_slice (
  input  logic                        clk_i,
  input  logic                        ndmreset_n,
  input  logic                        slc_valid_i,
  input  xbar_pkg::op_e               slc_op_i,
  input  logic [`XBAR_ID_W-1:0]       slc_id_i,
  input  logic [`XBAR_WORD_SEL_W-1:0] slc_word_i,
  input  logic [`XBAR_DATA_W-1:0]     slc_wdata_i,
  output logic                        slc_credit_o,
  output logic                        rsp_valid_o,
  output logic [`XBAR_ID_W-1:0]       rsp_id_o,
  output logic [`XBAR_DATA_W-1:0]     rsp_rdata_o,
  input  logic                        rsp_ack_i
);
  import xbar_pkg::*;

  localparam int PtrW = $clog2(`XBAR_SLICE_DEPTH);
  localparam int CntW = $clog2(`XBAR_SLICE_DEPTH + 1);

  op_e                          q_op    [`XBAR_SLICE_DEPTH];
  logic [`XBAR_ID_W-1:0]        q_id    [`XBAR_SLICE_DEPTH];
  logic [`XBAR_WORD_SEL_W-1:0]  q_word  [`XBAR_SLICE_DEPTH];
  logic [`XBAR_DATA_W-1:0]      q_wdata [`XBAR_SLICE_DEPTH];
  logic [PtrW-1:0]              wr_ptr_q;
  logic [PtrW-1:0]              rd_ptr_q;
  logic [CntW-1:0]              count_q;
  logic [`XBAR_DATA_W-1:0]      mem_q   [`XBAR_SLICE_WORDS];

  logic                         q_empty;
  logic                         head_valid;
  op_e                          head_op;
  logic [`XBAR_ID_W-1:0]        head_id;
  logic [`XBAR_WORD_SEL_W-1:0]  head_word;
  logic [`XBAR_DATA_W-1:0]      head_wdata;
  logic                         load;
  logic                         push;
  logic                         pop;

  assign q_empty = (count_q == '0);

  // Empty queue lets the incoming request through to the response register
  assign head_valid = !q_empty || slc_valid_i;
  assign head_op    = q_empty ? slc_op_i    : q_op[rd_ptr_q];
  assign head_id    = q_empty ? slc_id_i    : q_id[rd_ptr_q];
  assign head_word  = q_empty ? slc_word_i  : q_word[rd_ptr_q];
  assign head_wdata = q_empty ? slc_wdata_i : q_wdata[rd_ptr_q];

  assign load = head_valid && (!rsp_valid_o || rsp_ack_i);
  assign pop  = load && !q_empty;
  assign push = slc_valid_i && !(q_empty && load);

  always_ff @(posedge clk_i) begin
    if (push) begin
      q_op[wr_ptr_q]    <= slc_op_i;
      q_id[wr_ptr_q]    <= slc_id_i;
      q_word[wr_ptr_q]  <= slc_word_i;
      q_wdata[wr_ptr_q] <= slc_wdata_i;
    end
    if (load) begin
      rsp_id_o    <= head_id;
      rsp_rdata_o <= (head_op == OP_WRITE) ? '0 : mem_q[head_word];
    end
  end

  // Storage starts out cleared
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      for (int i = 0; i < `XBAR_SLICE_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (load && head_op == OP_WRITE) begin
      mem_q[head_word] <= head_wdata;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      rsp_valid_o  <= 1'b0;
      slc_credit_o <= 1'b0;
    end else begin
      slc_credit_o <= load;
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(`XBAR_SLICE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(`XBAR_SLICE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push && pop) begin
        count_q <= count_q - 1'b1;
      end
      if (load) begin
        rsp_valid_o <= 1'b1;
      end else if (rsp_ack_i) begin
        rsp_valid_o <= 1'b0;
      end
    end
  end

endmodule

/* hw/rsp_arbiter.sv */
`include "xbar_defines.svh"

module rsp_arbiter (
  input  logic                                      clk_i,
  input  logic                                      ndmreset_n,
  input  logic [`XBAR_N_SLICES-1:0]                 slc_valid_i,
  input  logic [`XBAR_N_SLICES-1:0][`XBAR_ID_W-1:0] slc_id_i,
  input  logic [`XBAR_N_SLICES-1:0][`XBAR_DATA_W-1:0] slc_rdata_i,
  output logic [`XBAR_N_SLICES-1:0]                 slc_ack_o,
  input  logic                                      err_valid_i,
  input  logic [`XBAR_ID_W-1:0]                     err_id_i,
  output logic                                      err_ack_o,
  input  logic                                      rsp_credit_i,
  output logic                                      rsp_valid_o,
  output logic [`XBAR_ID_W-1:0]                     rsp_id_o,
  output xbar_pkg::rsp_status_e                     rsp_status_o,
  output logic [`XBAR_DATA_W-1:0]                   rsp_rdata_o
);
  import xbar_pkg::*;

  // Slices take the low indices and the decode-error slot the last one
  localparam int NSrc   = `XBAR_N_SLICES + 1;
  localparam int SrcW   = $clog2(NSrc);
  localparam int ErrIdx = `XBAR_N_SLICES;
  localparam int CrdW   = $clog2(`XBAR_RSP_CREDITS + 1);

  logic [NSrc-1:0]                   req;
  logic [NSrc-1:0]                   gnt;
  logic [SrcW-1:0]                   gnt_idx;
  logic [SrcW-1:0]                   last_q;
  logic [NSrc-1:0][`XBAR_ID_W-1:0]   src_id;
  logic [NSrc-1:0][`XBAR_DATA_W-1:0] src_rdata;
  logic [CrdW-1:0]                   crd_q;
  logic                              issue;

  assign req       = {err_valid_i, slc_valid_i};
  assign src_id    = {err_id_i, slc_id_i};
  assign src_rdata = {{`XBAR_DATA_W{1'b0}}, slc_rdata_i};

  // Search starts one past the last winner
  always_comb begin
    int unsigned idx;
    gnt     = '0;
    gnt_idx = '0;
    for (int unsigned k = 1; k <= NSrc; k++) begin
      idx = (32'(last_q) + k) % NSrc;
      if (req[idx] && gnt == '0) begin
        gnt[idx] = 1'b1;
        gnt_idx  = idx[SrcW-1:0];
      end
    end
  end

  assign issue     = (|req) && (crd_q != '0);
  assign slc_ack_o = gnt[`XBAR_N_SLICES-1:0] & {`XBAR_N_SLICES{issue}};
  assign err_ack_o = gnt[ErrIdx] & issue;

  always_ff @(posedge clk_i) begin
    if (issue) begin
      rsp_id_o     <= src_id[gnt_idx];
      rsp_rdata_o  <= src_rdata[gnt_idx];
      rsp_status_o <= (gnt_idx == SrcW'(ErrIdx)) ? RSP_DECERR : RSP_OKAY;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_o <= 1'b0;
      last_q      <= SrcW'(NSrc - 1);
      crd_q       <= CrdW'(`XBAR_RSP_CREDITS);
    end else begin
      rsp_valid_o <= issue;
      if (issue) begin
        last_q <= gnt_idx;
      end
      if (issue && !rsp_credit_i) begin
        crd_q <= crd_q - 1'b1;
      end else if (!issue && rsp_credit_i) begin
        crd_q <= crd_q + 1'b1;
      end
    end
  end

endmodule

/* hw/mem_xbar_top.sv */
`include "xbar_defines.svh"

module mem_xbar_top (
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic                    req_valid_i,
  input  xbar_pkg::op_e           req_op_i,
  input  logic [`XBAR_ID_W-1:0]   req_id_i,
  input  logic [`XBAR_ADDR_W-1:0] req_addr_i,
  input  logic [`XBAR_DATA_W-1:0] req_wdata_i,
  output logic                    req_credit_o,
  output logic                    rsp_valid_o,
  output logic [`XBAR_ID_W-1:0]   rsp_id_o,
  output xbar_pkg::rsp_status_e   rsp_status_o,
  output logic [`XBAR_DATA_W-1:0] rsp_rdata_o,
  input  logic                    rsp_credit_i
);
  import xbar_pkg::*;

  logic [`XBAR_N_SLICES-1:0]                   slc_valid;
  op_e                                         slc_op;
  logic [`XBAR_ID_W-1:0]                       slc_id;
  logic [`XBAR_WORD_SEL_W-1:0]                 slc_word;
  logic [`XBAR_DATA_W-1:0]                     slc_wdata;
  logic [`XBAR_N_SLICES-1:0]                   slc_credit;
  logic [`XBAR_N_SLICES-1:0]                   srsp_valid;
  logic [`XBAR_N_SLICES-1:0][`XBAR_ID_W-1:0]   srsp_id;
  logic [`XBAR_N_SLICES-1:0][`XBAR_DATA_W-1:0] srsp_rdata;
  logic [`XBAR_N_SLICES-1:0]                   srsp_ack;
  logic                                        err_valid;
  logic [`XBAR_ID_W-1:0]                       err_id;
  logic                                        err_ack;

  // --------------------------------------------------------------------------
  // Ingress and decode
  // --------------------------------------------------------------------------
  req_decoder i_decoder (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .req_valid_i  ( req_valid_i  ),
    .req_op_i     ( req_op_i     ),
    .req_id_i     ( req_id_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_wdata_i  ( req_wdata_i  ),
    .req_credit_o ( req_credit_o ),
    .slc_valid_o  ( slc_valid    ),
    .slc_op_o     ( slc_op       ),
    .slc_id_o     ( slc_id       ),
    .slc_word_o   ( slc_word     ),
    .slc_wdata_o  ( slc_wdata    ),
    .slc_credit_i ( slc_credit   ),
    .err_valid_o  ( err_valid    ),
    .err_id_o     ( err_id       ),
    .err_ack_i    ( err_ack      )
  );

  // --------------------------------------------------------------------------
  // Memory slices
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < `XBAR_N_SLICES; i++) begin : g_slice
    mem_slice i_slice (
      .clk_i        ( clk_i         ),
      .ndmreset_n   ( ndmreset_n    ),
      .slc_valid_i  ( slc_valid[i]  ),
      .slc_op_i     ( slc_op        ),
      .slc_id_i     ( slc_id        ),
      .slc_word_i   ( slc_word      ),
      .slc_wdata_i  ( slc_wdata     ),
      .slc_credit_o ( slc_credit[i] ),
      .rsp_valid_o  ( srsp_valid[i] ),
      .rsp_id_o     ( srsp_id[i]    ),
      .rsp_rdata_o  ( srsp_rdata[i] ),
      .rsp_ack_i    ( srsp_ack[i]   )
    );
  end

  // Response merge
  rsp_arbiter i_arbiter (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .slc_valid_i  ( srsp_valid   ),
    .slc_id_i     ( srsp_id      ),
    .slc_rdata_i  ( srsp_rdata   ),
    .slc_ack_o    ( srsp_ack     ),
    .err_valid_i  ( err_valid    ),
    .err_id_i     ( err_id       ),
    .err_ack_o    ( err_ack      ),
    .rsp_credit_i ( rsp_credit_i ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_id_o     ( rsp_id_o     ),
    .rsp_status_o ( rsp_status_o ),
    .rsp_rdata_o  ( rsp_rdata_o  )
  );

endmodule

/* testbench/tb_mem_xbar.sv */
`include "xbar_defines.svh"

module tb_mem_xbar;
  import xbar_pkg::*;

  localparam int          WaitLimit = 200;
  localparam int          BpReqs    = 16;
  localparam logic [31:0] WinBase   = 32'h1000_0000;

  logic                    clk_i = 1'b0;
  logic                    ndmreset_n;
  logic                    req_valid_i;
  op_e                     req_op_i;
  logic [`XBAR_ID_W-1:0]   req_id_i;
  logic [`XBAR_ADDR_W-1:0] req_addr_i;
  logic [`XBAR_DATA_W-1:0] req_wdata_i;
  logic                    req_credit_o;
  logic                    rsp_valid_o;
  logic [`XBAR_ID_W-1:0]   rsp_id_o;
  rsp_status_e             rsp_status_o;
  logic [`XBAR_DATA_W-1:0] rsp_rdata_o;
  logic                    rsp_credit_i = 1'b0;

  // Stimulus table with expected response per entry
  op_e                     tbl_op     [$];
  logic [`XBAR_ID_W-1:0]   tbl_id     [$];
  logic [`XBAR_ADDR_W-1:0] tbl_addr   [$];
  logic [`XBAR_DATA_W-1:0] tbl_data   [$];
  rsp_status_e             tbl_status [$];
  logic [`XBAR_DATA_W-1:0] tbl_rdata  [$];
  logic [`XBAR_DATA_W-1:0] model_mem  [`XBAR_N_SLICES * `XBAR_SLICE_WORDS];

  logic [`XBAR_ID_W-1:0]   got_id     [$];
  rsp_status_e             got_status [$];
  logic [`XBAR_DATA_W-1:0] got_rdata  [$];

  int credits_back;
  int credits_used;
  int rsp_credits_given;
  bit withhold;
  int errors;
  int checks;

  mem_xbar_top dut0 (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .req_valid_i  ( req_valid_i  ),
    .req_op_i     ( req_op_i     ),
    .req_id_i     ( req_id_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_wdata_i  ( req_wdata_i  ),
    .req_credit_o ( req_credit_o ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_id_o     ( rsp_id_o     ),
    .rsp_status_o ( rsp_status_o ),
    .rsp_rdata_o  ( rsp_rdata_o  ),
    .rsp_credit_i ( rsp_credit_i )
  );

  always #5 clk_i = ~clk_i;

  // Response log and request credit count
  always @(posedge clk_i) begin
    if (req_credit_o === 1'b1) begin
      credits_back++;
    end
    if (rsp_valid_o === 1'b1) begin
      got_id.push_back(rsp_id_o);
      got_status.push_back(rsp_status_o);
      got_rdata.push_back(rsp_rdata_o);
    end
  end

  // One response credit per logged response one cycle later
  always @(negedge clk_i) begin
    if (!withhold && got_id.size() > rsp_credits_given) begin
      rsp_credit_i = 1'b1;
      rsp_credits_given++;
    end else begin
      rsp_credit_i = 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] slot_addr(input int slice, input int word);
    return WinBase + (32'(slice) << 12) + (32'(word) << 2);
  endfunction

  task automatic add_req(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                         input rsp_status_e status);
    logic [5:0] idx;
    idx = {addr[13:12], addr[5:2]};
    tbl_op.push_back(op);
    tbl_id.push_back(4'($urandom));
    tbl_addr.push_back(addr);
    tbl_data.push_back(data);
    tbl_status.push_back(status);
    if (status == RSP_OKAY && op == OP_READ) begin
      tbl_rdata.push_back(model_mem[idx]);
    end else begin
      tbl_rdata.push_back('0);
    end
    if (status == RSP_OKAY && op == OP_WRITE) begin
      model_mem[idx] = data;
    end
  endtask

  task automatic wait_req_credit();
    int waited;
    waited = 0;
    while ((`XBAR_IN_DEPTH + credits_back - credits_used) <= 0 && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    assert (waited < WaitLimit) else begin
      $display("Timeout at %0t: no request credit came back", $time);
      errors++;
    end
  endtask

  task automatic wait_rsp_count(input int target);
    int waited;
    waited = 0;
    while (got_id.size() < target && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    assert (waited < WaitLimit) else begin
      $display("Timeout at %0t: expected response did not arrive", $time);
      errors++;
    end
  endtask

  // Starts on a falling edge and returns on the next one
  task automatic drive_req(input int i);
    req_valid_i = 1'b1;
    req_op_i    = tbl_op[i];
    req_id_i    = tbl_id[i];
    req_addr_i  = tbl_addr[i];
    req_wdata_i = tbl_data[i];
    credits_used++;
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic check_rsp(input int i, input int k);
    check_val("rsp_id_o", 32'(got_id[k]), 32'(tbl_id[i]));
    check_val("rsp_status_o", 32'(got_status[k]), 32'(tbl_status[i]));
    check_val("rsp_rdata_o", got_rdata[k], tbl_rdata[i]);
  endtask

  task automatic run_group(input int first, input int last, input string name);
    int err0;
    int base;
    err0 = errors;
    for (int i = first; i < last; i++) begin
      base = got_id.size();
      wait_req_credit();
      drive_req(i);
      wait_rsp_count(base + 1);
      if (got_id.size() > base) begin
        check_rsp(i, base);
      end
    end
    $display("Test %-12s %0d requests, %0d errors", name, last - first, errors - err0);
  endtask

  task automatic run_backpressure();
    int first;
    int base;
    int err0;
    int sent;
    int idle;
    int back0;
    int hits;
    first = tbl_op.size();
    err0  = errors;
    for (int k = 0; k < BpReqs; k++) begin
      add_req((k % 4 < 2) ? OP_WRITE : OP_READ, slot_addr(k % 2, 8 + k / 4), $urandom,
              RSP_OKAY);
      tbl_id[first + k] = 4'(k);
    end
    @(posedge clk_i);
    withhold = 1'b1;
    @(negedge clk_i);
    base = got_id.size();
    sent = 0;
    idle = 0;
    // Fill the fabric until request credits stop coming back
    while (sent < BpReqs && idle < 30) begin
      if ((`XBAR_IN_DEPTH + credits_back - credits_used) > 0) begin
        drive_req(first + sent);
        sent++;
        idle = 0;
      end else begin
        @(negedge clk_i);
        idle++;
      end
    end
    assert (sent < BpReqs) else begin
      $display("Error at %0t: request credits never ran out under back-pressure", $time);
      errors++;
    end
    back0 = credits_back;
    repeat (20) @(negedge clk_i);
    check_val("req_credit_o pulses", credits_back, back0);
    assert (got_id.size() - base <= `XBAR_RSP_CREDITS) else begin
      $display("Error at %0t: %0d responses sent without credits", $time, got_id.size() - base);
      errors++;
    end
    @(posedge clk_i);
    withhold = 1'b0;
    @(negedge clk_i);
    while (sent < BpReqs) begin
      wait_req_credit();
      drive_req(first + sent);
      sent++;
    end
    wait_rsp_count(base + BpReqs);
    repeat (10) @(negedge clk_i);
    check_val("response count", got_id.size() - base, BpReqs);
    for (int k = 0; k < BpReqs; k++) begin
      hits = 0;
      for (int j = base; j < got_id.size(); j++) begin
        if (got_id[j] == 4'(k)) begin
          hits++;
          check_rsp(first + k, j);
        end
      end
      check_val("responses per id", hits, 1);
    end
    $display("Test %-12s %0d requests, %0d errors", "backpressure", BpReqs, errors - err0);
  endtask

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------
  initial begin
    int first;
    int err0;
    void'($urandom(20));
    ndmreset_n  = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = OP_READ;
    req_id_i    = '0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    errors      = 0;
    checks      = 0;
    for (int i = 0; i < `XBAR_N_SLICES * `XBAR_SLICE_WORDS; i++) begin
      model_mem[i] = '0;
    end

    err0 = errors;
    repeat (5) begin
      @(negedge clk_i);
      check_val("rsp_valid_o", rsp_valid_o, 0);
      check_val("req_credit_o", req_credit_o, 0);
    end
    ndmreset_n = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      check_val("rsp_valid_o", rsp_valid_o, 0);
      check_val("req_credit_o", req_credit_o, 0);
    end
    check_val("response count", got_id.size(), 0);
    $display("Test %-12s %0d errors", "reset", errors - err0);

    first = tbl_op.size();
    for (int s = 0; s < `XBAR_N_SLICES; s++) begin
      add_req(OP_READ, slot_addr(s, 0), '0, RSP_OKAY);
    end
    run_group(first, tbl_op.size(), "first_reads");

    first = tbl_op.size();
    for (int s = 0; s < `XBAR_N_SLICES; s++) begin
      for (int w = 0; w < `XBAR_SLICE_WORDS; w++) begin
        add_req(OP_WRITE, slot_addr(s, w), $urandom, RSP_OKAY);
        add_req(OP_READ, slot_addr(s, w), '0, RSP_OKAY);
      end
    end
    run_group(first, tbl_op.size(), "write_read");

    // Outside the window, bits 11..6 set, misaligned
    first = tbl_op.size();
    add_req(OP_WRITE, 32'h2000_0004, $urandom, RSP_DECERR);
    add_req(OP_READ, slot_addr(0, 1), '0, RSP_OKAY);
    add_req(OP_WRITE, WinBase + 32'h48, $urandom, RSP_DECERR);
    add_req(OP_READ, slot_addr(0, 2), '0, RSP_OKAY);
    add_req(OP_WRITE, slot_addr(2, 3) + 32'h1, $urandom, RSP_DECERR);
    add_req(OP_READ, slot_addr(2, 3), '0, RSP_OKAY);
    add_req(OP_READ, 32'h1000_4000, '0, RSP_DECERR);
    add_req(OP_READ, 32'h0FFF_FFFC, '0, RSP_DECERR);
    run_group(first, tbl_op.size(), "decode_error");

    first = tbl_op.size();
    add_req(OP_WRITE, slot_addr(0, 5), $urandom, RSP_OKAY);
    add_req(OP_WRITE, slot_addr(1, 5), $urandom, RSP_OKAY);
    add_req(OP_READ, slot_addr(0, 5), '0, RSP_OKAY);
    add_req(OP_READ, slot_addr(1, 5), '0, RSP_OKAY);
    run_group(first, tbl_op.size(), "slice_indep");

    run_backpressure();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+hw
hw/xbar_pkg.sv
hw/req_decoder.sv
hw/mem_slice.sv
hw/rsp_arbiter.sv
hw/mem_xbar_top.sv
testbench/tb_mem_xbar.sv

/* run.sh */
#!/bin/sh
# Compile and run the crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_xbar -Mdir obj_dir -o tb_mem_xbar -f src.f

./obj_dir/tb_mem_xbar > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
